// File: oberon_io.f
rtl/oberon_io_pkg.sv
rtl/io_regs.sv
rtl/ms_timer.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/spi_master.sv
rtl/oberon_io_top.sv
test/tb_oberon_io.sv

// File: rtl/io_regs.sv
/* Wishbone classic slave for the I/O word addresses. Acks each access
   once, holds the control registers and turns accesses into start pulses. */
`timescale 1ns/1ps
`default_nettype none

module io_regs
    import oberon_io_pkg::*;
(
    input  wire logic        clk_cpu_i,
    input  wire logic        rst_n_i,
    input  wire wb_req_t     wb_req_i,
    output wb_rsp_t          wb_rsp_o,
    input  wire logic [31:0] ms_count_i,
    input  wire uart_stat_t  uart_stat_i,
    input  wire logic [7:0]  rx_data_i,
    output logic             rx_done_o,
    output logic             tx_start_o,
    output logic [7:0]       tx_data_o,
    output logic             baud_fast_o,
    input  wire logic        spi_rdy_i,
    input  wire logic [31:0] spi_rx_i,
    output logic             spi_start_o,
    output logic [31:0]      spi_tx_o,
    output spi_ctrl_t        spi_ctrl_o,
    output logic [7:0]       led_o
);

    logic              ack_q;
    logic [DATA_W-1:0] rdat_q;
    logic              req;      // access seen and not yet acked
    logic              wr_acc, rd_acc;
    logic [DATA_W-1:0] rd_data;

    assign req = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_acc = req & wb_req_i.we;
    assign rd_acc = req & ~wb_req_i.we;
    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

    always_comb begin
        case (wb_req_i.adr)
            ADDR_MS:        rd_data = ms_count_i;
            ADDR_UART_DATA: rd_data = {24'h0, rx_data_i};
            ADDR_UART_STAT: rd_data = {30'h0, uart_stat_i};
            ADDR_SPI_DATA:  rd_data = spi_rx_i;
            ADDR_SPI_STAT:  rd_data = {31'h0, spi_rdy_i};
            default:        rd_data = '0;   // LED is write only, 6..15 unused
        endcase
    end

    // handshake, pulses and control registers
    always_ff @(posedge clk_cpu_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            tx_start_o <= 1'b0;
            spi_start_o <= 1'b0;
            rx_done_o <= 1'b0;
            led_o <= 8'h0;
            baud_fast_o <= 1'b0;
            spi_ctrl_o <= '0;
        end else begin
            ack_q <= req;
            tx_start_o <= wr_acc && wb_req_i.adr == ADDR_UART_DATA;
            spi_start_o <= wr_acc && wb_req_i.adr == ADDR_SPI_DATA;
            rx_done_o <= rd_acc && wb_req_i.adr == ADDR_UART_DATA;   // frees the rx holding reg
            if (wr_acc) begin
                case (wb_req_i.adr)
                    ADDR_LED:       led_o <= wb_req_i.dat[7:0];
                    ADDR_UART_STAT: baud_fast_o <= wb_req_i.dat[0];
                    ADDR_SPI_STAT:  spi_ctrl_o <= wb_req_i.dat[2:0];
                    default:        ;
                endcase
            end
        end
    end

    // read data and outgoing payloads
    always_ff @(posedge clk_cpu_i) begin
        if (rd_acc)
            rdat_q <= rd_data;
        if (wr_acc && wb_req_i.adr == ADDR_UART_DATA)
            tx_data_o <= wb_req_i.dat[7:0];
        if (wr_acc && wb_req_i.adr == ADDR_SPI_DATA)
            spi_tx_o <= wb_req_i.dat;
    end

    // a held request must not be acked twice
    assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        ack_q |=> !ack_q);

    // starts come with the ack of their write
    assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        (tx_start_o || spi_start_o) |-> ack_q ##1 !(tx_start_o || spi_start_o));

endmodule

`default_nettype wire

// File: rtl/ms_timer.sv
/* Free-running millisecond counter, read by software at word address 0. */
`timescale 1ns/1ps
`default_nettype none

module ms_timer
    import oberon_io_pkg::*;
(
    input  wire logic  clk_cpu_i,
    input  wire logic  rst_n_i,
    output logic [31:0] ms_count_o
);

    logic [MS_PRE_W-1:0] pre_q;   // cycles within the current ms

    always_ff @(posedge clk_cpu_i) begin
        if (!rst_n_i) begin
            pre_q <= '0;
            ms_count_o <= 32'h0;
        end else if (pre_q == MS_PRE_W'(MS_DIV - 1)) begin
            pre_q <= '0;
            ms_count_o <= ms_count_o + 32'd1;
        end else begin
            pre_q <= pre_q + MS_PRE_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: rtl/oberon_io_pkg.sv
/* Shared constants and bus types for the Oberon I/O block.
   Modules pull them in with a wildcard import in their header. */
`default_nettype none

package oberon_io_pkg;

    localparam int CLK_HZ = 250_000_000;        // clk_cpu, 4 ns period
    localparam int MS_DIV = CLK_HZ / 1000;      // cycles per millisecond
    localparam int MS_PRE_W = $clog2(MS_DIV);

    localparam int BAUD_SLOW = 19_200;
    localparam int BAUD_FAST = 115_200;
    localparam int BIT_CYC_SLOW = CLK_HZ / BAUD_SLOW;
    localparam int BIT_CYC_FAST = CLK_HZ / BAUD_FAST;
    localparam int BIT_CNT_W = $clog2(BIT_CYC_SLOW);   // wide enough for both rates

    localparam int SPI_HALF_SLOW = 313;         // about 400 kHz for card init
    localparam int SPI_HALF_FAST = 4;
    localparam int SPI_DIV_W = $clog2(SPI_HALF_SLOW);

    localparam int ADR_W = 4;
    localparam int DATA_W = 32;

    // word addresses of the I/O registers
    localparam logic [ADR_W-1:0] ADDR_MS = 4'd0;
    localparam logic [ADR_W-1:0] ADDR_LED = 4'd1;
    localparam logic [ADR_W-1:0] ADDR_UART_DATA = 4'd2;
    localparam logic [ADR_W-1:0] ADDR_UART_STAT = 4'd3;
    localparam logic [ADR_W-1:0] ADDR_SPI_DATA = 4'd4;
    localparam logic [ADR_W-1:0] ADDR_SPI_STAT = 4'd5;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;   // byte lanes, all registers are full words
        logic [ADR_W-1:0]  adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic rdy_tx;
        logic rdy_rx;
    } uart_stat_t;

    typedef struct packed {
        logic fast;    // 32-bit transfers at the fast sck
        logic spare;
        logic sel;     // SD-card select, active high here
    } spi_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/oberon_io_top.sv
/* I/O block of the workstation SoC: Wishbone register slave plus timer,
   UART and SD-card SPI. An external bus master drives the register port. */
`timescale 1ns/1ps
`default_nettype none

module oberon_io_top
    import oberon_io_pkg::*;
(
    input  wire logic    clk_cpu_i,
    input  wire logic    rst_n_i,
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o,
    input  wire logic    rx_i,
    output logic         tx_o,
    output logic [7:0]   led_o,
    input  wire logic    sd_do_i,
    output logic         sd_di_o,
    output logic         sd_ck_o,
    output logic         sd_cs_n_o
);

    logic [31:0] ms_count;
    uart_stat_t  uart_stat;
    logic        rdy_tx, rdy_rx;
    logic [7:0]  rx_data, tx_data;
    logic        rx_done, tx_start, baud_fast;
    logic        spi_rdy, spi_start;
    logic [31:0] spi_rx, spi_tx;
    spi_ctrl_t   spi_ctrl;

    assign uart_stat = '{rdy_tx: rdy_tx, rdy_rx: rdy_rx};
    assign sd_cs_n_o = ~spi_ctrl.sel;   // card select is active low

    io_regs u_regs (
        .clk_cpu_i, .rst_n_i, .wb_req_i, .wb_rsp_o,
        .ms_count_i(ms_count), .uart_stat_i(uart_stat), .rx_data_i(rx_data),
        .rx_done_o(rx_done), .tx_start_o(tx_start), .tx_data_o(tx_data),
        .baud_fast_o(baud_fast), .spi_rdy_i(spi_rdy), .spi_rx_i(spi_rx),
        .spi_start_o(spi_start), .spi_tx_o(spi_tx), .spi_ctrl_o(spi_ctrl),
        .led_o
    );

    ms_timer u_timer (.clk_cpu_i, .rst_n_i, .ms_count_o(ms_count));

    uart_rx u_rx (
        .clk_cpu_i, .rst_n_i, .rx_i, .baud_fast_i(baud_fast), .done_i(rx_done),
        .data_o(rx_data), .rdy_o(rdy_rx)
    );

    uart_tx u_tx (
        .clk_cpu_i, .rst_n_i, .start_i(tx_start), .baud_fast_i(baud_fast),
        .data_i(tx_data), .tx_o, .rdy_o(rdy_tx)
    );

    spi_master u_spi (
        .clk_cpu_i, .rst_n_i, .start_i(spi_start), .fast_i(spi_ctrl.fast),
        .data_i(spi_tx), .miso_i(sd_do_i), .data_o(spi_rx), .rdy_o(spi_rdy),
        .sck_o(sd_ck_o), .mosi_o(sd_di_o)
    );

endmodule

`default_nettype wire

// File: rtl/spi_master.sv
/* SPI mode-0 master for the SD card. Slow mode moves one byte at about
   400 kHz, fast mode a 32-bit word, most significant bit first. */
`timescale 1ns/1ps
`default_nettype none

module spi_master
    import oberon_io_pkg::*;
(
    input  wire logic        clk_cpu_i,
    input  wire logic        rst_n_i,
    input  wire logic        start_i,
    input  wire logic        fast_i,
    input  wire logic [31:0] data_i,
    input  wire logic        miso_i,
    output logic [31:0]      data_o,
    output logic             rdy_o,
    output logic             sck_o,
    output logic             mosi_o
);

    logic                 busy_q;
    logic                 fast_q;     // mode held for the whole transfer
    logic                 sck_q;
    logic                 rx_bit_q;   // sampled on the rising edge
    logic [4:0]           bit_q;
    logic [SPI_DIV_W-1:0] div_q;
    logic [SPI_DIV_W-1:0] half_lim;
    logic [31:0]          shreg_q;
    logic                 last_bit;
    logic                 half_end;

    assign half_lim = fast_q ? SPI_DIV_W'(SPI_HALF_FAST - 1) : SPI_DIV_W'(SPI_HALF_SLOW - 1);
    assign last_bit = bit_q == (fast_q ? 5'd31 : 5'd7);
    assign half_end = div_q == half_lim;
    assign rdy_o = ~busy_q;
    assign sck_o = sck_q;
    assign mosi_o = shreg_q[31];
    assign data_o = shreg_q;

    always_ff @(posedge clk_cpu_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            fast_q <= 1'b0;
            sck_q <= 1'b0;
            bit_q <= 5'd0;
            div_q <= '0;
            shreg_q <= '1;   // mosi idles high
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q <= 1'b1;
                fast_q <= fast_i;
                bit_q <= 5'd0;
                div_q <= '0;
                // a byte goes to the top so it leaves msb first
                shreg_q <= fast_i ? data_i : {data_i[7:0], 24'h0};
            end
        end else if (sck_q && last_bit) begin
            sck_q <= 1'b0;   // finish right after the last sample
            busy_q <= 1'b0;
            shreg_q <= {shreg_q[30:0], rx_bit_q};
        end else if (!half_end) begin
            div_q <= div_q + SPI_DIV_W'(1);
        end else begin
            div_q <= '0;
            sck_q <= ~sck_q;
            if (sck_q) begin   // falling edge, next bit onto mosi
                shreg_q <= {shreg_q[30:0], rx_bit_q};
                bit_q <= bit_q + 5'd1;
            end
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        if (busy_q && !sck_q && half_end)
            rx_bit_q <= miso_i;
    end

    assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        rdy_o |-> !sck_o);

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
/* UART receiver, 8N1 at the slow or fast bit rate. The byte is held
   with rdy_o set until the register block pulses done_i. */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import oberon_io_pkg::*;
(
    input  wire logic clk_cpu_i,
    input  wire logic rst_n_i,
    input  wire logic rx_i,
    input  wire logic baud_fast_i,
    input  wire logic done_i,
    output logic [7:0] data_o,
    output logic       rdy_o
);

    logic [2:0]           sync_q;   // two sync flops plus edge history
    logic                 rx_s;
    logic                 fall;
    logic                 busy_q;
    logic [3:0]           bit_q;    // 0 start, 1..8 data, 9 stop
    logic [BIT_CNT_W-1:0] cnt_q;
    logic [BIT_CNT_W-1:0] bit_lim;
    logic [7:0]           shreg_q;
    logic                 tick;

    assign rx_s = sync_q[1];
    assign fall = sync_q[2] & ~sync_q[1];
    assign bit_lim = baud_fast_i ? BIT_CNT_W'(BIT_CYC_FAST - 1) : BIT_CNT_W'(BIT_CYC_SLOW - 1);
    assign tick = busy_q && cnt_q == '0;   // mid-bit sample point

    always_ff @(posedge clk_cpu_i) begin
        if (!rst_n_i) begin
            sync_q <= 3'b111;
            busy_q <= 1'b0;
            bit_q <= 4'd0;
            cnt_q <= '0;
            rdy_o <= 1'b0;
        end else begin
            sync_q <= {sync_q[1:0], rx_i};
            if (done_i)
                rdy_o <= 1'b0;
            if (!busy_q) begin
                if (fall) begin
                    busy_q <= 1'b1;
                    bit_q <= 4'd0;
                    cnt_q <= bit_lim >> 1;   // half a bit to reach the middle
                end
            end else if (!tick) begin
                cnt_q <= cnt_q - BIT_CNT_W'(1);
            end else begin
                cnt_q <= bit_lim;
                bit_q <= bit_q + 4'd1;
                if (bit_q == 4'd0 && rx_s)
                    busy_q <= 1'b0;   // glitch, not a start bit
                else if (bit_q == 4'd9) begin
                    busy_q <= 1'b0;
                    if (rx_s)
                        rdy_o <= 1'b1;   // good stop bit wins over done_i
                end
            end
        end
    end

    always_ff @(posedge clk_cpu_i) begin
        if (tick && bit_q >= 4'd1 && bit_q <= 4'd8)
            shreg_q <= {rx_s, shreg_q[7:1]};   // lsb arrives first
        if (tick && bit_q == 4'd9 && rx_s)
            data_o <= shreg_q;
    end

    assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        $rose(rdy_o) |-> !busy_q && $past(bit_q) == 4'd9);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
/* UART transmitter, 8N1 at the slow or fast bit rate. A start while
   busy is dropped, software polls rdy_o first. */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import oberon_io_pkg::*;
(
    input  wire logic       clk_cpu_i,
    input  wire logic       rst_n_i,
    input  wire logic       start_i,
    input  wire logic       baud_fast_i,
    input  wire logic [7:0] data_i,
    output logic            tx_o,
    output logic            rdy_o
);

    logic                 busy_q;
    logic [3:0]           bit_q;     // bits already sent in this frame
    logic [BIT_CNT_W-1:0] cnt_q;
    logic [BIT_CNT_W-1:0] bit_lim;
    logic [9:0]           shreg_q;   // stop, data, start

    assign bit_lim = baud_fast_i ? BIT_CNT_W'(BIT_CYC_FAST - 1) : BIT_CNT_W'(BIT_CYC_SLOW - 1);
    assign tx_o = shreg_q[0];
    assign rdy_o = ~busy_q;

    always_ff @(posedge clk_cpu_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            bit_q <= 4'd0;
            cnt_q <= '0;
            shreg_q <= '1;   // idle line high
        end else if (!busy_q) begin
            if (start_i) begin
                busy_q <= 1'b1;
                bit_q <= 4'd0;
                cnt_q <= '0;
                shreg_q <= {1'b1, data_i, 1'b0};
            end
        end else if (cnt_q != bit_lim) begin
            cnt_q <= cnt_q + BIT_CNT_W'(1);
        end else begin
            cnt_q <= '0;
            shreg_q <= {1'b1, shreg_q[9:1]};   // ones fill in behind the stop bit
            if (bit_q == 4'd9)
                busy_q <= 1'b0;
            else
                bit_q <= bit_q + 4'd1;
        end
    end

    assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        rdy_o |-> tx_o);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The run counts as passed only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_oberon_io -f oberon_io.f \
    && ./obj_dir/Vtb_oberon_io | tee /dev/stderr | grep -q "TB PASSED" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: test/tb_oberon_io.sv
/* Testbench for the I/O block. Acts as the Wishbone master, loops the UART
   and SPI pins back and checks the register map, transfers and timer. */
`timescale 1ns/1ps
`default_nettype none

module tb_oberon_io
    import oberon_io_pkg::*;
();

    localparam int CLK_NS = 4;
    localparam int RST_CYC = 5;
    localparam int ACK_WAIT = 8;       // cycles before a missing ack counts as a hang
    localparam int RDY_TX_BIT = 1;     // uart_stat_t layout
    localparam int RDY_RX_BIT = 0;
    localparam int SEL_BIT = 0;        // spi_ctrl_t layout
    localparam int FAST_BIT = 2;
    // two of each UART frame, the timer interval twice over, and the SPI words
    localparam int WATCHDOG_CYC = 2 * (10 * (BIT_CYC_SLOW + BIT_CYC_FAST) + 2 * MS_DIV)
                                  + 80 * SPI_HALF_SLOW;

    logic        clk_cpu;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        uart_line;   // tx_o looped into rx_i
    logic        sd_loop;     // mosi looped into miso
    logic [7:0]  led;
    logic        sd_ck;
    logic        sd_cs_n;
    logic [31:0] seed_init;

    oberon_io_top DUT (
        .clk_cpu_i(clk_cpu), .rst_n_i(rst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
        .rx_i(uart_line), .tx_o(uart_line), .led_o(led),
        .sd_do_i(sd_loop), .sd_di_o(sd_loop), .sd_ck_o(sd_ck), .sd_cs_n_o(sd_cs_n)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #(CLK_NS / 2) clk_cpu = ~clk_cpu;
    end

    task automatic fail_value(input string test, input logic [31:0] exp, input logic [31:0] act);
        $display("** Error [%s] expected 0x%08h actual 0x%08h at %0t", test, exp, act, $time);
        $display("TB FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic fail_text(input string what);
        $display("Error: %s at %0t", what, $time);
        $display("TB FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_NS);
        fail_text($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYC));
    end

    // a new request is acked on the next clock
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (wb_req.cyc && wb_req.stb && !$past(wb_req.cyc && wb_req.stb)) |=> wb_rsp.ack)
        else fail_text("ack did not come one cycle after the request");

    // ack only for a held request, and only once
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        wb_rsp.ack |-> ((wb_req.cyc && wb_req.stb) ##1 !wb_rsp.ack))
        else fail_text("ack outside a request or repeated");

    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (wb_rsp.ack && wb_req.we && wb_req.adr == ADDR_LED) |-> led == wb_req.dat[7:0])
        else fail_value("led write", {24'h0, wb_req.dat[7:0]}, {24'h0, led});

    // card select follows the control word
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (wb_rsp.ack && wb_req.we && wb_req.adr == ADDR_SPI_STAT)
        |-> sd_cs_n == !wb_req.dat[SEL_BIT])
        else fail_value("card select", {31'h0, !wb_req.dat[SEL_BIT]}, {31'h0, sd_cs_n});

    // start bit leaves right after a data write
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (wb_rsp.ack && wb_req.we && wb_req.adr == ADDR_UART_DATA) |=> !uart_line)
        else fail_value("uart start bit", 32'h0, {31'h0, uart_line});

    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        sd_cs_n |-> !sd_ck)
        else fail_text("sd clock toggled with the card deselected");

    task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else fail_value(test, exp, act);
    endtask

    task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk_cpu);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.sel = 4'hf;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(negedge clk_cpu);
            waited++;
            if (waited > ACK_WAIT)
                fail_text($sformatf("no ack within %0d cycles at address %0d", ACK_WAIT, adr));
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(negedge clk_cpu);   // cycle ends at the edge that sees ack
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic read_check(input string test, input logic [ADR_W-1:0] adr,
                              input logic [31:0] exp);
        logic [31:0] rdat;
        wb_read(adr, rdat);
        check_eq(test, exp, rdat);
    endtask

    task automatic wait_bit_set(input logic [ADR_W-1:0] adr, input int bitn);
        logic [31:0] rdat;
        rdat = '0;
        while (!rdat[bitn])
            wb_read(adr, rdat);   // watchdog ends a stuck poll
    endtask

    task automatic after_reset();
        check_eq("reset led", 32'h0, {24'h0, led});
        check_eq("reset tx line", 32'h1, {31'h0, uart_line});
        check_eq("reset card select", 32'h1, {31'h0, sd_cs_n});
        check_eq("reset sd clock", 32'h0, {31'h0, sd_ck});
        read_check("reset uart status", ADDR_UART_STAT, 32'h1 << RDY_TX_BIT);
        read_check("reset spi status", ADDR_SPI_STAT, 32'h1);
    endtask

    task automatic register_map();
        logic [31:0] val;
        val = '0;
        repeat (4) begin
            val = $urandom;
            wb_write(ADDR_LED, val);
            read_check("led reads zero", ADDR_LED, 32'h0);
        end
        check_eq("led holds", {24'h0, val[7:0]}, {24'h0, led});
        for (int a = 6; a < 16; a++) begin
            wb_write(ADR_W'(a), $urandom);   // must be dropped
            read_check($sformatf("unused address %0d", a), ADR_W'(a), 32'h0);
        end
    endtask

    task automatic uart_loopback(input logic fast);
        logic [7:0]  byte_out;
        logic [31:0] rdat;
        string       mode;
        mode = fast ? "fast" : "slow";
        byte_out = 8'($urandom);
        wb_write(ADDR_UART_STAT, {31'h0, fast});
        wb_write(ADDR_UART_DATA, {24'h0, byte_out});
        read_check({"uart busy ", mode}, ADDR_UART_STAT, 32'h0);
        wait_bit_set(ADDR_UART_STAT, RDY_RX_BIT);
        read_check({"uart byte ", mode}, ADDR_UART_DATA, {24'h0, byte_out});
        wb_read(ADDR_UART_STAT, rdat);
        check_eq({"uart rx cleared ", mode}, 32'h0, {31'h0, rdat[RDY_RX_BIT]});
        wait_bit_set(ADDR_UART_STAT, RDY_TX_BIT);   // stop bit finished
    endtask

    task automatic spi_loopback(input logic fast);
        logic [31:0] word;
        logic [31:0] exp;
        word = $urandom;
        exp = fast ? word : {24'h0, word[7:0]};   // slow moves one byte
        wb_write(ADDR_SPI_STAT, (32'(fast) << FAST_BIT) | (32'h1 << SEL_BIT));
        check_eq("card selected", 32'h0, {31'h0, sd_cs_n});
        wb_write(ADDR_SPI_DATA, word);
        wait_bit_set(ADDR_SPI_STAT, 0);
        read_check(fast ? "spi word fast" : "spi byte slow", ADDR_SPI_DATA, exp);
        wb_write(ADDR_SPI_STAT, 32'h0);
    endtask

    task automatic timer_rate();
        logic [31:0] first;
        logic [31:0] prev;
        logic [31:0] now;
        wb_read(ADDR_MS, first);
        prev = first;
        repeat (4) begin
            repeat (MS_DIV / 2) @(negedge clk_cpu);
            wb_read(ADDR_MS, now);
            assert (now >= prev) else fail_value("ms counter monotonic", prev, now);
            prev = now;
        end
        assert (now - first == 32'd2 || now - first == 32'd3)
            else fail_value("ms counter over 2 ms", 32'd2, now - first);
    endtask

    initial begin
        seed_init = $urandom(51);
        wb_req = '0;
        rst_n = 1'b0;
        repeat (RST_CYC) @(negedge clk_cpu);
        rst_n = 1'b1;
        after_reset();
        register_map();
        uart_loopback(1'b1);
        uart_loopback(1'b0);
        spi_loopback(1'b1);
        spi_loopback(1'b0);
        timer_rate();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
